/* hdl/lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Board switches
`define LSU_SW_LO        32'h0000_7800
`define LSU_SW_HI        32'h0000_780F

// LED banks, red below green
`define LSU_LEDR_LO      32'h0000_7000
`define LSU_LEDR_HI      32'h0000_700F
`define LSU_LEDG_LO      32'h0000_7010
`define LSU_LEDG_HI      32'h0000_701F

// Data memory window
`define LSU_DMEM_LO      32'h0000_2000
`define LSU_DMEM_HI      32'h0000_3FFF
`define LSU_DREMAP_HI    32'h0000_23FF   // Top of the remapped low window
`define LSU_DMEM_REMAP_MASK 32'hFFFF_DFFF // Clears bit 13

// Instruction memory, base at zero
`define LSU_IMEM_HI      32'h0000_1FFF

// 1 KiB data memory
`define LSU_DMEM_WORDS   256

`endif

/* hdl/lsu_pkg.sv */
package lsu_pkg;

	// Region code seen by the load path
	typedef enum logic [1:0] {
		SEL_SW   = 2'd0,  // Switches, also the default region
		SEL_LED  = 2'd1,  // Red or green LEDs
		SEL_DMEM = 2'd2,
		SEL_IMEM = 2'd3
	} lsu_sel_e;

	// Load/store funct3
	typedef enum logic [2:0] {
		B  = 3'b000,
		H  = 3'b001,
		W  = 3'b010,
		BU = 3'b100,
		HU = 3'b101
	} lsu_size_e;

	// Request straight from the core
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [2:0]  funct3;
		logic        wren;   // Store strobe
		logic        rden;   // Load strobe
	} lsu_req_t;

	// Decoder result, purely combinational
	typedef struct packed {
		lsu_sel_e    sel;
		logic        wr_dmem;
		logic        wr_ledr;
		logic        wr_ledg;
		logic [3:0]  wbe;     // Store lane enables
		logic [31:0] waddr;   // Size-aligned store address
		logic [31:0] raddr;   // Word-aligned load address
		logic [31:0] wdata;   // Store data spread over the lanes
		logic        ledg;    // Read pick, green bank when set
	} lsu_dec_t;

endpackage

/* hdl/lsu_addr_decoder.sv */
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_addr_decoder (
	input  lsu_pkg::lsu_req_t i_req,
	output lsu_pkg::lsu_dec_t o_dec
);

	logic              in_sw;
	logic              in_ledg;
	logic              in_ledr;
	logic              in_dmem;
	logic              in_imem;
	logic              in_remap;
	logic [31:0]       map_addr;
	lsu_pkg::lsu_sel_e sel;

	// Region hits on the raw address
	assign in_sw    = (i_req.addr >= `LSU_SW_LO)   && (i_req.addr <= `LSU_SW_HI);
	assign in_ledg  = (i_req.addr >= `LSU_LEDG_LO) && (i_req.addr <= `LSU_LEDG_HI);
	assign in_ledr  = (i_req.addr >= `LSU_LEDR_LO) && (i_req.addr <= `LSU_LEDR_HI);
	assign in_dmem  = (i_req.addr >= `LSU_DMEM_LO) && (i_req.addr <= `LSU_DMEM_HI);
	assign in_imem  = (i_req.addr <= `LSU_IMEM_HI);   // Base is zero
	assign in_remap = (i_req.addr >= `LSU_DMEM_LO) && (i_req.addr <= `LSU_DREMAP_HI);

	// Low data window folds down by clearing bit 13
	assign map_addr = in_remap ? (i_req.addr & `LSU_DMEM_REMAP_MASK) : i_req.addr;

	// Priority: switches, green, red, dmem, imem
	always_comb begin
		if (in_sw) begin
			sel = lsu_pkg::SEL_SW;
		end else if (in_ledg) begin
			sel = lsu_pkg::SEL_LED;
		end else if (in_ledr) begin
			sel = lsu_pkg::SEL_LED;
		end else if (in_dmem) begin
			sel = lsu_pkg::SEL_DMEM;
		end else if (in_imem) begin
			sel = lsu_pkg::SEL_IMEM;
		end else begin
			sel = lsu_pkg::SEL_SW;   // Unmapped reads the switches
		end
	end

	always_comb begin
		o_dec       = '0;
		o_dec.sel   = sel;
		o_dec.raddr = {map_addr[31:2], 2'b00};
		o_dec.ledg  = i_req.addr[4];
		o_dec.wdata = i_req.wdata;

		// Store address, lanes and data by size
		case (i_req.funct3)
			lsu_pkg::B: begin
				o_dec.waddr = map_addr;
				o_dec.wbe   = 4'b0001 << map_addr[1:0];   // One-hot lane
				o_dec.wdata = {4{i_req.wdata[7:0]}};     // Byte on every lane
			end
			lsu_pkg::H: begin
				o_dec.waddr = {map_addr[31:1], 1'b0};
				o_dec.wdata = {2{i_req.wdata[15:0]}};
				// Offset taken before alignment so a misaligned half writes nothing
				case (map_addr[1:0])
					2'b00:   o_dec.wbe = 4'b0011;
					2'b10:   o_dec.wbe = 4'b1100;
					default: o_dec.wbe = 4'b0000;
				endcase
			end
			lsu_pkg::W: begin
				o_dec.waddr = {map_addr[31:2], 2'b00};
				o_dec.wbe   = 4'b1111;
			end
			default: begin
				o_dec.waddr = 32'h0000_0000;   // Not a store size
				o_dec.wbe   = 4'b0000;
			end
		endcase

		// One-hot region strobes, imem never written
		o_dec.wr_dmem = i_req.wren && (sel == lsu_pkg::SEL_DMEM);
		o_dec.wr_ledg = i_req.wren && (sel == lsu_pkg::SEL_LED) && in_ledg;
		o_dec.wr_ledr = i_req.wren && (sel == lsu_pkg::SEL_LED) && !in_ledg;
	end

endmodule : lsu_addr_decoder

/* hdl/lsu_data_mem.sv */
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_data_mem (
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_we,
	input  logic [3:0]  i_wbe,
	input  logic [31:0] i_waddr,
	input  logic [31:0] i_raddr,
	input  logic [31:0] i_wdata,
	output logic [31:0] o_rdata
);

	localparam int IDX_W = $clog2(`LSU_DMEM_WORDS);   // 8 for 256 words

	logic [31:0]      mem [`LSU_DMEM_WORDS];
	logic [IDX_W-1:0] widx;
	logic [IDX_W-1:0] ridx;

	// Word index from bits 9:2, upper bits alias
	assign widx = i_waddr[IDX_W+1:2];
	assign ridx = i_raddr[IDX_W+1:2];

	// Byte-lane write
	always_ff @(posedge i_clk) begin
		if (i_we) begin
			for (int b = 0; b < 4; b++) begin
				if (i_wbe[b]) begin
					mem[widx][b*8 +: 8] <= i_wdata[b*8 +: 8];
				end
			end
		end
	end

	// Registered read, sees the word before a same-edge write
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_rdata <= '0;
		end else begin
			o_rdata <= mem[ridx];
		end
	end

endmodule : lsu_data_mem

/* hdl/lsu_io_buffers.sv */
`timescale 1ns/10ps

module lsu_io_buffers (
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_wr_ledr,
	input  logic        i_wr_ledg,
	input  logic [3:0]  i_wbe,
	input  logic [31:0] i_wdata,
	input  logic [31:0] i_sw,
	output logic [31:0] o_ledr,
	output logic [31:0] o_ledg,
	output logic [31:0] o_sw_word
);

	logic [31:0] ledr_q;
	logic [31:0] ledg_q;
	logic [31:0] sw_meta;   // First sync stage
	logic [31:0] sw_sync;

	// LED banks, byte-wise under own strobe
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ledr_q <= '0;   // LEDs dark out of reset
			ledg_q <= '0;
		end else begin
			for (int b = 0; b < 4; b++) begin
				if (i_wr_ledr && i_wbe[b]) begin
					ledr_q[b*8 +: 8] <= i_wdata[b*8 +: 8];
				end
				if (i_wr_ledg && i_wbe[b]) begin
					ledg_q[b*8 +: 8] <= i_wdata[b*8 +: 8];
				end
			end
		end
	end

	// Switches are asynchronous to the core clock
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sw_meta <= '0;
			sw_sync <= '0;
		end else begin
			sw_meta <= i_sw;
			sw_sync <= sw_meta;   // Two cycles from pin to word
		end
	end

	assign o_ledr    = ledr_q;
	assign o_ledg    = ledg_q;
	assign o_sw_word = sw_sync;

endmodule : lsu_io_buffers

/* hdl/lsu_load_unit.sv */
`timescale 1ns/10ps

module lsu_load_unit (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_rden,
	input  lsu_pkg::lsu_sel_e  i_sel,
	input  logic               i_ledg,
	input  lsu_pkg::lsu_size_e i_funct3,
	input  logic [1:0]         i_offset,
	input  logic [31:0]        i_dmem_word,
	input  logic [31:0]        i_sw_word,
	input  logic [31:0]        i_ledr_word,
	input  logic [31:0]        i_ledg_word,
	output logic [31:0]        o_ld_data,
	output logic               o_ld_valid
);

	lsu_pkg::lsu_sel_e  sel_q;
	lsu_pkg::lsu_size_e funct3_q;
	logic [1:0]         off_q;
	logic [31:0]        io_word;
	logic [31:0]        io_q;     // I/O word at the load edge
	logic               valid_q;
	logic [31:0]        src;
	logic [31:0]        shifted;

	// I/O source picked at issue
	assign io_word = (i_sel == lsu_pkg::SEL_LED) ?
		(i_ledg ? i_ledg_word : i_ledr_word) : i_sw_word;

	// Load context, one set per strobe
	always_ff @(posedge i_clk) begin
		if (i_rden) begin
			sel_q    <= i_sel;
			funct3_q <= i_funct3;
			off_q    <= i_offset;
			io_q     <= io_word;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_rden;   // One cycle behind the strobe
		end
	end

	// Source word in the result cycle
	always_comb begin
		case (sel_q)
			lsu_pkg::SEL_DMEM: src = i_dmem_word;   // Already registered in dmem
			lsu_pkg::SEL_IMEM: src = 32'h0000_0000;
			default:           src = io_q;
		endcase
	end

	assign shifted = src >> {off_q, 3'b000};   // Addressed byte down to lane 0

	// Extend by size
	always_comb begin
		case (funct3_q)
			lsu_pkg::B:  o_ld_data = {{24{shifted[7]}}, shifted[7:0]};
			lsu_pkg::H:  o_ld_data = {{16{shifted[15]}}, shifted[15:0]};
			lsu_pkg::W:  o_ld_data = shifted;
			lsu_pkg::BU: o_ld_data = {24'h0, shifted[7:0]};
			lsu_pkg::HU: o_ld_data = {16'h0, shifted[15:0]};
			default:     o_ld_data = src;   // Whole word, no shift
		endcase
	end

	assign o_ld_valid = valid_q;

endmodule : lsu_load_unit

/* hdl/lsu_top.sv */
`timescale 1ns/10ps

module lsu_top (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  lsu_pkg::lsu_req_t i_req,
	input  logic [31:0]       i_sw,
	output logic [31:0]       o_ld_data,
	output logic              o_ld_valid,
	output logic [31:0]       o_ledr,
	output logic [31:0]       o_ledg,
	output logic [31:0]       o_sw_seen
);

	lsu_pkg::lsu_dec_t dec;
	logic [31:0]       dmem_word;
	logic [31:0]       sw_word;   // Synchronized switches

	lsu_addr_decoder u_dec (
		.i_req (i_req),
		.o_dec (dec)
	);

	lsu_data_mem u_dmem (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_we    (dec.wr_dmem),
		.i_wbe   (dec.wbe),
		.i_waddr (dec.waddr),
		.i_raddr (dec.raddr),
		.i_wdata (dec.wdata),
		.o_rdata (dmem_word)
	);

	// LED outputs double as the readback words
	lsu_io_buffers u_io (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_wr_ledr (dec.wr_ledr),
		.i_wr_ledg (dec.wr_ledg),
		.i_wbe     (dec.wbe),
		.i_wdata   (dec.wdata),
		.i_sw      (i_sw),
		.o_ledr    (o_ledr),
		.o_ledg    (o_ledg),
		.o_sw_word (sw_word)
	);

	lsu_load_unit u_ld (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_rden      (i_req.rden),
		.i_sel       (dec.sel),
		.i_ledg      (dec.ledg),
		.i_funct3    (lsu_pkg::lsu_size_e'(i_req.funct3)),
		.i_offset    (i_req.addr[1:0]),
		.i_dmem_word (dmem_word),
		.i_sw_word   (sw_word),
		.i_ledr_word (o_ledr),
		.i_ledg_word (o_ledg),
		.o_ld_data   (o_ld_data),
		.o_ld_valid  (o_ld_valid)
	);

	assign o_sw_seen = sw_word;

endmodule : lsu_top

/* testbench/tb_lsu.sv */
`timescale 1ns/10ps
`include "lsu_params.svh"

module tb_lsu;

	// Region codes of the model, RG_NONE is outside the map
	localparam int RG_SW   = 0;
	localparam int RG_LEDR = 1;
	localparam int RG_LEDG = 2;
	localparam int RG_DMEM = 3;
	localparam int RG_IMEM = 4;
	localparam int RG_NONE = 5;
	localparam int VALID_TIMEOUT = 8;   // Cycles before a missing valid is fatal

	logic              i_clk;
	logic              i_rst_n;
	lsu_pkg::lsu_req_t i_req;
	logic [31:0]       i_sw;
	logic [31:0]       o_ld_data;
	logic              o_ld_valid;
	logic [31:0]       o_ledr;
	logic [31:0]       o_ledg;
	logic [31:0]       o_sw_seen;

	// Reference model state
	logic [31:0] mem_model [`LSU_DMEM_WORDS];
	logic [31:0] ledr_model;
	logic [31:0] ledg_model;
	logic [31:0] sw_p1;            // Switch pipeline, first stage
	logic [31:0] sw_p2;            // Readable switch word
	logic [31:0] sw_val;           // Next value for the switch pins
	logic [31:0] lfsr_state = 32'd17;

	lsu_top u_dut (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_req      (i_req),
		.i_sw       (i_sw),
		.o_ld_data  (o_ld_data),
		.o_ld_valid (o_ld_valid),
		.o_ledr     (o_ledr),
		.o_ledg     (o_ledg),
		.o_sw_seen  (o_sw_seen)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// Two-deep switch model, same edges as the board sync
	always @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sw_p1 <= '0;
			sw_p2 <= '0;
		end else begin
			sw_p1 <= i_sw;
			sw_p2 <= sw_p1;
		end
	end

	// Galois LFSR, taps for x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);   // One step per bit
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Any 3-bit code, the three unused ones included
	function automatic logic [2:0] pick_funct3();
		logic [31:0] v;
		v = rand_bits(3);
		return v[2:0];
	endfunction

	function automatic int rand_region();
		return int'(rand_bits(3) % 6);
	endfunction

	function automatic logic [31:0] rand_addr(input int rg);
		case (rg)
			RG_SW:           return `LSU_SW_LO + rand_bits(4);
			RG_LEDR, RG_LEDG: return `LSU_LEDR_LO + rand_bits(5);   // Both banks
			RG_DMEM:         return `LSU_DMEM_LO + rand_bits(13);   // Low window and aliases
			RG_IMEM:         return rand_bits(13);
			default:         return 32'h0001_0000 + rand_bits(16); // Unmapped
		endcase
	endfunction

	// Address map in the given priority
	function automatic int region_of(input logic [31:0] a);
		if (a >= `LSU_SW_LO && a <= `LSU_SW_HI) return RG_SW;
		if (a >= `LSU_LEDG_LO && a <= `LSU_LEDG_HI) return RG_LEDG;
		if (a >= `LSU_LEDR_LO && a <= `LSU_LEDR_HI) return RG_LEDR;
		if (a >= `LSU_DMEM_LO && a <= `LSU_DMEM_HI) return RG_DMEM;
		if (a <= `LSU_IMEM_HI) return RG_IMEM;
		return RG_SW;   // Anything else reads the switches
	endfunction

	function automatic lsu_pkg::lsu_req_t make_req(input logic [31:0] addr,
		input logic [31:0] wdata, input logic [2:0] f3, input logic wren, input logic rden);
		lsu_pkg::lsu_req_t r;
		r.addr   = addr;
		r.wdata  = wdata;
		r.funct3 = f3;
		r.wren   = wren;
		r.rden   = rden;
		return r;
	endfunction

	// Expected load result from the model as it stands before the edge
	function automatic logic [31:0] expect_load(input logic [31:0] a, input logic [2:0] f3);
		logic [31:0] word;
		logic [31:0] sh;
		case (region_of(a))
			RG_DMEM: word = mem_model[a[9:2]];   // 1 KiB, bits 9:2 only
			RG_LEDR: word = ledr_model;
			RG_LEDG: word = ledg_model;
			RG_IMEM: word = 32'h0000_0000;
			default: word = sw_p2;
		endcase
		sh = word >> (32'(a[1:0]) * 32'd8);
		case (f3)
			lsu_pkg::B:  return {{24{sh[7]}}, sh[7:0]};
			lsu_pkg::H:  return {{16{sh[15]}}, sh[15:0]};
			lsu_pkg::W:  return sh;
			lsu_pkg::BU: return {24'h0, sh[7:0]};
			lsu_pkg::HU: return {16'h0, sh[15:0]};
			default:     return word;
		endcase
	endfunction

	// Store rules on the model
	task automatic apply_store(input lsu_pkg::lsu_req_t req);
		logic [3:0]  be;
		logic [31:0] lanes;
		logic [1:0]  off;
		int          rg;
		off   = req.addr[1:0];
		lanes = req.wdata << (32'(off) * 32'd8);   // Store data into its lanes
		rg    = region_of(req.addr);
		case (req.funct3)
			lsu_pkg::B: be = 4'b0001 << off;
			lsu_pkg::H: be = (off == 2'd0) ? 4'b0011 : (off == 2'd2) ? 4'b1100 : 4'b0000;
			lsu_pkg::W: begin
				be    = 4'b1111;
				lanes = req.wdata;
			end
			default: be = 4'b0000;
		endcase
		if (req.wren) begin
			for (int b = 0; b < 4; b++) begin
				if (be[b]) begin
					case (rg)
						RG_DMEM: mem_model[req.addr[9:2]][b*8 +: 8] = lanes[b*8 +: 8];
						RG_LEDR: ledr_model[b*8 +: 8] = lanes[b*8 +: 8];
						RG_LEDG: ledg_model[b*8 +: 8] = lanes[b*8 +: 8];
						default: ;   // Switches and imem keep nothing
					endcase
				end
			end
		end
	endtask

	task automatic stop_on_error();
		$display("** FAIL **");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic compare_value(input string name, input logic [31:0] act,
		input logic [31:0] exp);
		if (act !== exp) begin
			$display("error %s: got 0x%08h, expected 0x%08h", name, act, exp);
			stop_on_error();
		end
	endtask

	// Poll for the load valid, idling the request meanwhile
	task automatic wait_valid(output int cycles);
		lsu_pkg::lsu_req_t idle;
		idle   = '0;
		cycles = 1;
		while (o_ld_valid !== 1'b1) begin
			if (cycles >= VALID_TIMEOUT) begin
				$display("timeout: no load valid within %0d cycles of the load", VALID_TIMEOUT);
				stop_on_error();
			end else begin
				i_req = idle;
				@(posedge i_clk);
				@(negedge i_clk);
				cycles++;
			end
		end
	endtask

	// One request, driven on the falling edge and checked on the next one
	task automatic drive_cycle(input lsu_pkg::lsu_req_t req);
		logic [31:0] exp_data;
		int          lat;
		exp_data = expect_load(req.addr, req.funct3);   // Old data wins
		i_req    = req;
		i_sw     = sw_val;
		apply_store(req);
		@(posedge i_clk);
		@(negedge i_clk);
		if (req.rden) begin
			wait_valid(lat);
			compare_value("ld_latency", lat, 32'd1);
			compare_value("o_ld_data", o_ld_data, exp_data);
		end else begin
			compare_value("o_ld_valid", 32'(o_ld_valid), 32'd0);
		end
		compare_value("o_ledr", o_ledr, ledr_model);
		compare_value("o_ledg", o_ledg, ledg_model);
		compare_value("o_sw_seen", o_sw_seen, sw_p2);
	endtask

	task automatic random_cycle(input int rg);
		lsu_pkg::lsu_req_t req;
		req.addr   = rand_addr(rg);
		req.wdata  = rand_bits(32);
		req.funct3 = pick_funct3();
		req.wren   = rand_bits(1) != 0;
		req.rden   = rand_bits(1) != 0;   // Both set gives a same-word pair
		drive_cycle(req);
	endtask

	initial begin
		lsu_pkg::lsu_req_t req;
		i_rst_n    = 1'b0;
		i_req      = '0;
		i_sw       = '0;
		sw_val     = '0;
		ledr_model = '0;
		ledg_model = '0;
		repeat (5) @(posedge i_clk);
		@(negedge i_clk);
		compare_value("o_ld_valid", 32'(o_ld_valid), 32'd0);
		compare_value("o_ledr", o_ledr, 32'd0);
		compare_value("o_ledg", o_ledg, 32'd0);
		i_rst_n = 1'b1;

		// Known contents in every dmem word
		for (int i = 0; i < `LSU_DMEM_WORDS; i++) begin
			drive_cycle(make_req(`LSU_DMEM_LO + i * 4, rand_bits(32), lsu_pkg::W, 1'b1, 1'b0));
		end
		repeat (400) random_cycle(RG_DMEM);

		// Misaligned halves write nothing, whole word read back
		repeat (16) begin
			req = make_req(rand_addr(RG_DMEM) | 32'h1, rand_bits(32), lsu_pkg::H, 1'b1, 1'b1);
			drive_cycle(req);
			drive_cycle(make_req({req.addr[31:2], 2'b00}, 32'd0, lsu_pkg::W, 1'b0, 1'b1));
		end

		// LED banks byte by byte, then read back
		for (int bank = 0; bank < 2; bank++) begin
			for (int b = 0; b < 4; b++) begin
				drive_cycle(make_req(`LSU_LEDR_LO + bank * 16 + b, rand_bits(32), lsu_pkg::B,
					1'b1, 1'b0));
			end
		end
		drive_cycle(make_req(`LSU_LEDR_LO, 32'd0, lsu_pkg::W, 1'b0, 1'b1));
		drive_cycle(make_req(`LSU_LEDG_LO, 32'd0, lsu_pkg::W, 1'b0, 1'b1));
		repeat (80) random_cycle(RG_LEDR);

		// Switches through the sync, then via 0x7800 and unmapped space
		repeat (20) begin
			sw_val = rand_bits(32);
			repeat (2) drive_cycle('0);
			drive_cycle(make_req(rand_addr(RG_SW), 32'd0, pick_funct3(), 1'b0, 1'b1));
			drive_cycle(make_req(rand_addr(RG_NONE), 32'd0, pick_funct3(), 1'b0, 1'b1));
		end

		repeat (80) random_cycle(RG_IMEM);   // Stores dropped, loads zero

		// Loads every cycle across the map
		repeat (120) begin
			drive_cycle(make_req(rand_addr(rand_region()), 32'd0, pick_funct3(), 1'b0, 1'b1));
		end

		// Mixed traffic with moving switches
		repeat (400) begin
			if (rand_bits(3) == 32'd0) begin
				sw_val = rand_bits(32);
			end
			random_cycle(rand_region());
		end

		// Whole memory against the model, through the alias window
		for (int i = 0; i < `LSU_DMEM_WORDS; i++) begin
			drive_cycle(make_req(32'h0000_2400 + i * 4, 32'd0, lsu_pkg::W, 1'b0, 1'b1));
		end
		drive_cycle('0);

		$display("** PASS **");
		$finish;
	end

endmodule : tb_lsu

/* tb.f */
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_addr_decoder.sv
hdl/lsu_data_mem.sv
hdl/lsu_io_buffers.sv
hdl/lsu_load_unit.sv
hdl/lsu_top.sv
testbench/tb_lsu.sv

/* Makefile */
# Verilator simulation of the LSU testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= ** PASS **

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
